// ==== design/pipe_params.svh ====
// Sizing constants shared by the package and the RTL
// Register indices and opcodes follow the RV32 base encoding
// Queue depth must be at least 2; any depth is accepted, not only powers of two

`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Width of a register index, 32 architectural registers
`define PIPE_REG_IDX_W 5

// Width of the major opcode field
`define PIPE_OPCODE_W 7

// Entries in the instruction queue between decode and issue
`define PIPE_QUEUE_DEPTH 4

`endif

// ==== design/pipe_pkg.sv ====
// Types shared by the decode, queue and issue logic
// Only the major opcodes below are classified, others are carried as raw values
// Register zero is hardwired and never counts as a read or a write

`include "pipe_params.svh"

package pipe_pkg;

    // Architectural register index
    typedef logic [`PIPE_REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes that affect operand usage
    typedef enum logic [`PIPE_OPCODE_W-1:0]
    {
        OP_R_TYPE = 7'b0110011,
        OP_I_ALU  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // One decoded instruction as held in the queue
    typedef struct packed
    {
        // Raw major opcode, may hold a value outside the enum
        opcode_e  opcode;
        // Source and destination indices as received
        reg_idx_t src1;
        reg_idx_t src2;
        reg_idx_t dst;
        // Operand usage, already cleared for register zero
        logic     reads_src1;
        logic     reads_src2;
        logic     writes_dst;
    } decoded_instr_t;

endpackage

// ==== design/instr_decoder.sv ====
// Classifies the major opcode into source and destination usage
// One decoded instruction per input strobe, one cycle of latency
// No back-pressure; a strobe is always decoded
// Unknown opcodes read nothing and write nothing

`include "pipe_params.svh"

module instr_decoder
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [`PIPE_OPCODE_W-1:0] op_code,
    input  pipe_pkg::reg_idx_t        src1,
    input  pipe_pkg::reg_idx_t        src2,
    input  pipe_pkg::reg_idx_t        dst,
    output logic                      dec_valid,
    output pipe_pkg::decoded_instr_t  dec_instr
);
    import pipe_pkg::*;

    // Usage by opcode class, before the register zero check
    logic use_src1;
    logic use_src2;
    logic use_dst;

    always_comb
    begin
        use_src1 = 1'b0;
        use_src2 = 1'b0;
        use_dst  = 1'b0;
        case (opcode_e'(op_code))
            // Two register operands and a result
            OP_R_TYPE:
            begin
                use_src1 = 1'b1;
                use_src2 = 1'b1;
                use_dst  = 1'b1;
            end
            // Store reads base and data, branch compares two registers
            OP_STORE, OP_BRANCH:
            begin
                use_src1 = 1'b1;
                use_src2 = 1'b1;
            end
            // Base or operand in src1, src2 field is an immediate
            OP_LOAD, OP_I_ALU, OP_JALR:
            begin
                use_src1 = 1'b1;
                use_dst  = 1'b1;
            end
            // Unknown opcode behaves as a bubble with no operands
            default:
            begin
                use_src1 = 1'b0;
            end
        endcase
    end

    // Strobe delayed by one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= in_valid;
    end

    // Payload captured on the strobe only
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            dec_instr.opcode     <= opcode_e'(op_code);
            dec_instr.src1       <= src1;
            dec_instr.src2       <= src2;
            dec_instr.dst        <= dst;
            // x0 is never a true dependency
            dec_instr.reads_src1 <= use_src1 && (src1 != '0);
            dec_instr.reads_src2 <= use_src2 && (src2 != '0);
            dec_instr.writes_dst <= use_dst && (dst != '0);
        end
    end

endmodule

// ==== design/instr_queue.sv ====
// Circular FIFO between decode and issue, payload type set by parameter
// A push while full is dropped even if a pop happens in the same cycle
// A dropped push sets overflow, which stays set until reset
// Head is read straight from storage, so an entry is visible one cycle after push

`include "pipe_params.svh"

module instr_queue
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `PIPE_QUEUE_DEPTH
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     head_valid,
    output payload_t head_data,
    output logic     overflow
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign full       = (count == CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];
    assign do_push    = push && !full;
    // Pop without a valid head is ignored
    assign do_pop     = pop && head_valid;

    // Storage, no reset
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap explicitly so that any depth works
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            if (push && full)
                overflow <= 1'b1;
        end
    end

    // Consumer only pops a valid head
    a_pop_needs_head: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

    // Occupancy stays within the storage
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

endmodule

// ==== design/hazard_detector.sv ====
// Read-after-write check for the instruction at the queue head
// Compares against the destinations in execute and memory only
// Writeback writes before reads, so it is never a hazard source
// A destination of zero marks a bubble or a non-writing instruction

module hazard_detector
(
    input  pipe_pkg::reg_idx_t src1,
    input  pipe_pkg::reg_idx_t src2,
    input  logic               reads_src1,
    input  logic               reads_src2,
    input  pipe_pkg::reg_idx_t ex_dst,
    input  pipe_pkg::reg_idx_t mem_dst,
    output logic               stall
);
    // Stage holds a pending write
    logic ex_pending;
    logic mem_pending;

    // Per source and per stage matches
    logic src1_ex_hit;
    logic src1_mem_hit;
    logic src2_ex_hit;
    logic src2_mem_hit;

    // Conflict per source
    logic src1_conflict;
    logic src2_conflict;

    // x0 is never written, so a zero destination is no producer
    assign ex_pending  = (ex_dst != '0);
    assign mem_pending = (mem_dst != '0);

    // Producer one cycle ahead, still in execute
    assign src1_ex_hit  = ex_pending && (src1 == ex_dst);
    assign src2_ex_hit  = ex_pending && (src2 == ex_dst);

    // Producer two cycles ahead, in memory
    assign src1_mem_hit = mem_pending && (src1 == mem_dst);
    assign src2_mem_hit = mem_pending && (src2 == mem_dst);

    // Index fields only count when the instruction uses them
    assign src1_conflict = reads_src1 && (src1_ex_hit || src1_mem_hit);
    assign src2_conflict = reads_src2 && (src2_ex_hit || src2_mem_hit);

    // Either source pending holds the head
    assign stall = src1_conflict || src2_conflict;

endmodule

// ==== design/issue_pipeline.sv ====
// In-order issue from the queue head into execute, memory and writeback
// The head is held while a source is pending, bubbles enter execute meanwhile
// issue_valid is combinational and equals pop
// An instruction issued at t is in execute at t+1, memory at t+2, retires at t+3
// Non-writing instructions carry destination zero down the pipe

module issue_pipeline
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     head_valid,
    input  pipe_pkg::decoded_instr_t head_instr,
    output logic                     pop,
    output logic                     issue_valid,
    output pipe_pkg::reg_idx_t       issue_dst,
    output logic                     retire_valid,
    output pipe_pkg::opcode_e        retire_op,
    output pipe_pkg::reg_idx_t       retire_dst
);
    import pipe_pkg::*;

    logic     stall;

    // Stage registers
    logic     ex_valid;
    logic     mem_valid;
    logic     wb_valid;
    opcode_e  ex_op;
    opcode_e  mem_op;
    opcode_e  wb_op;
    reg_idx_t ex_dst;
    reg_idx_t mem_dst;
    reg_idx_t wb_dst;

    hazard_detector i_hazard
    (
        .src1       (head_instr.src1),
        .src2       (head_instr.src2),
        .reads_src1 (head_instr.reads_src1),
        .reads_src2 (head_instr.reads_src2),
        .ex_dst     (ex_dst),
        .mem_dst    (mem_dst),
        .stall      (stall)
    );

    // Issue the head as soon as its operands are settled
    assign pop         = head_valid && !stall;
    assign issue_valid = pop;
    assign issue_dst   = (pop && head_instr.writes_dst) ? head_instr.dst : '0;

    // Valid and destination shift; a zero destination is a bubble for the detector
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            ex_dst    <= '0;
            mem_dst   <= '0;
            wb_dst    <= '0;
        end
        else
        begin
            ex_valid  <= pop;
            ex_dst    <= issue_dst;
            mem_valid <= ex_valid;
            mem_dst   <= ex_dst;
            wb_valid  <= mem_valid;
            wb_dst    <= mem_dst;
        end
    end

    // Opcode only matters alongside its valid bit
    always_ff @(posedge clk)
    begin
        ex_op  <= head_instr.opcode;
        mem_op <= ex_op;
        wb_op  <= mem_op;
    end

    assign retire_valid = wb_valid;
    assign retire_op    = wb_op;
    assign retire_dst   = wb_dst;

    // A stalled head is not issued and is still at the queue head next cycle
    a_stall_holds_head: assert property (@(posedge clk) disable iff (!rst_n)
        (head_valid && stall) |-> !issue_valid ##1 (head_valid && $stable(head_instr)));

endmodule

// ==== design/issue_top.sv ====
// Decoder feeding the instruction queue, drained by the issue pipeline
// Input has no back-pressure; a strobe into a full queue is lost and sets overflow
// Input to retire takes 5 cycles plus any stall cycles

`include "pipe_params.svh"

module issue_top
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [`PIPE_OPCODE_W-1:0] op_code,
    input  pipe_pkg::reg_idx_t        src1,
    input  pipe_pkg::reg_idx_t        src2,
    input  pipe_pkg::reg_idx_t        dst,
    output logic                      issue_valid,
    output pipe_pkg::reg_idx_t        issue_dst,
    output logic                      retire_valid,
    output pipe_pkg::opcode_e         retire_op,
    output pipe_pkg::reg_idx_t        retire_dst,
    output logic                      overflow
);
    import pipe_pkg::*;

    // Decoder to queue
    logic           dec_valid;
    decoded_instr_t dec_instr;

    // Queue to issue
    logic           head_valid;
    decoded_instr_t head_instr;
    logic           pop;

    instr_decoder i_decoder
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op_code   (op_code),
        .src1      (src1),
        .src2      (src2),
        .dst       (dst),
        .dec_valid (dec_valid),
        .dec_instr (dec_instr)
    );

    instr_queue #(.payload_t(decoded_instr_t)) i_queue
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (dec_valid),
        .push_data  (dec_instr),
        .pop        (pop),
        .head_valid (head_valid),
        .head_data  (head_instr),
        .overflow   (overflow)
    );

    issue_pipeline i_issue
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head_instr   (head_instr),
        .pop          (pop),
        .issue_valid  (issue_valid),
        .issue_dst    (issue_dst),
        .retire_valid (retire_valid),
        .retire_op    (retire_op),
        .retire_dst   (retire_dst)
    );

endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock and synchronous active-low reset
// Reset is released on a rising edge after RESET_CYCLES full cycles

module clock_gen
#(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk,
    output logic rst_n
);
    // Free-running clock, first rising edge at half a period
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset low from time zero, released together with an edge
    initial
    begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/issue_tb.sv ====
// Testbench for the issue path with directed hazard tests and a random stream
// Expected issue cycles come from a reference model of the issue rules
// Cycle numbers count rising edges from time zero including reset
// Unknown opcodes are sent as 7'h7f

`include "pipe_params.svh"

module issue_tb;
    import pipe_pkg::*;

    localparam int         CLK_PERIOD   = 8;
    localparam int         RANDOM_COUNT = 200;
    // Issue spacing is at most 3 cycles plus slack for each directed test
    localparam int         EST_CYCLES   = 10 + 5 * 40 + RANDOM_COUNT * 3;
    localparam logic [6:0] OP_UNKNOWN   = 7'h7f;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [`PIPE_OPCODE_W-1:0] op_code;
    reg_idx_t                  src1;
    reg_idx_t                  src2;
    reg_idx_t                  dst;
    logic                      issue_valid;
    reg_idx_t                  issue_dst;
    logic                      retire_valid;
    opcode_e                   retire_op;
    reg_idx_t                  retire_dst;
    logic                      overflow;

    // Input history with one entry per strobe
    int         in_cycle [$];
    logic [6:0] in_op    [$];
    reg_idx_t   in_src1  [$];
    reg_idx_t   in_src2  [$];
    reg_idx_t   in_dst   [$];
    // Issue cycle per strobe or -1 when dropped
    int         in_issue [$];

    // Accepted instructions in issue order
    int         exp_issue [$];
    reg_idx_t   exp_dst   [$];
    logic [6:0] exp_op    [$];

    int   cyc          = 0;
    int   issue_idx    = 0;
    int   retire_idx   = 0;
    int   seed         = 69;
    int   errors       = 0;
    int   checks       = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   errors_at_start;
    int   test_dropped;
    logic dropped_any  = 1'b0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) i_clock
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_top i_dut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op_code      (op_code),
        .src1         (src1),
        .src2         (src2),
        .dst          (dst),
        .issue_valid  (issue_valid),
        .issue_dst    (issue_dst),
        .retire_valid (retire_valid),
        .retire_op    (retire_op),
        .retire_dst   (retire_dst),
        .overflow     (overflow)
    );

    // Value between two edges is the number of that cycle
    always @(posedge clk)
        cyc <= cyc + 1;

    // Operand usage by opcode class
    function automatic logic reads_first(logic [6:0] op);
        return op == OP_R_TYPE || op == OP_STORE || op == OP_BRANCH
            || op == OP_LOAD || op == OP_I_ALU || op == OP_JALR;
    endfunction

    function automatic logic reads_second(logic [6:0] op);
        return op == OP_R_TYPE || op == OP_STORE || op == OP_BRANCH;
    endfunction

    function automatic logic writes_result(logic [6:0] op);
        return op == OP_R_TYPE || op == OP_LOAD || op == OP_I_ALU || op == OP_JALR;
    endfunction

    // Expected issue cycle of strobe k or -1 when the queue is full at its push
    function automatic int expected_issue(int k);
        int   j;
        int   held;
        int   t;
        logic hit;
        held = 0;
        // Decode plus queue write
        t = in_cycle[k] + 2;
        for (j = 0; j < k; j++)
        begin
            if (in_issue[j] >= 0)
            begin
                // Still in the queue when k is pushed
                if (in_issue[j] > in_cycle[k])
                    held++;
                // In order and one per cycle
                if (in_issue[j] + 1 > t)
                    t = in_issue[j] + 1;
                hit = writes_result(in_op[j]) && (in_dst[j] != '0)
                    && ((reads_first(in_op[k]) && in_src1[k] == in_dst[j])
                    || (reads_second(in_op[k]) && in_src2[k] == in_dst[j]));
                // Writer must have left memory
                if (hit && in_issue[j] + 3 > t)
                    t = in_issue[j] + 3;
            end
        end
        if (held >= `PIPE_QUEUE_DEPTH)
            return -1;
        return t;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("mismatch at time %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    // One strobe followed by gap idle cycles
    task automatic send_instr(logic [6:0] op, reg_idx_t s1, reg_idx_t s2, reg_idx_t d,
                              int gap);
        int k;
        int t;
        @(posedge clk);
        in_valid <= 1'b1;
        op_code  <= op;
        src1     <= s1;
        src2     <= s2;
        dst      <= d;
        k = in_cycle.size();
        in_cycle.push_back(cyc + 1);
        in_op.push_back(op);
        in_src1.push_back(s1);
        in_src2.push_back(s2);
        in_dst.push_back(d);
        t = expected_issue(k);
        in_issue.push_back(t);
        if (t < 0)
        begin
            test_dropped++;
            dropped_any = 1'b1;
        end
        else
        begin
            exp_issue.push_back(t);
            exp_dst.push_back(writes_result(op) ? d : '0);
            exp_op.push_back(op);
        end
        repeat (gap)
        begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        test_dropped    = 0;
    endtask

    // Drains the pipe and then checks counts and the sticky flag
    task automatic end_test(string name);
        @(posedge clk);
        in_valid <= 1'b0;
        while (retire_idx < exp_issue.size())
            @(posedge clk);
        @(posedge clk);
        check_value("issue count", exp_issue.size(), issue_idx);
        check_value("overflow", int'(dropped_any), int'(overflow));
        tests_run++;
        if (errors != errors_at_start)
            tests_failed++;
        $display("test %s finished: %0d dropped, %0d errors",
                 name, test_dropped, errors - errors_at_start);
    endtask

    // Compare process for issue and retire events in program order
    always @(posedge clk)
    begin
        if (rst_n && issue_valid)
        begin
            if (issue_idx < exp_issue.size())
            begin
                check_value("issue cycle", exp_issue[issue_idx], cyc);
                check_value("issue_dst", int'(exp_dst[issue_idx]), int'(issue_dst));
            end
            else
            begin
                errors++;
                $display("issue at time %0t with no instruction expected", $time);
            end
            issue_idx++;
        end
        if (rst_n && retire_valid)
        begin
            if (retire_idx < exp_issue.size())
            begin
                check_value("retire cycle", exp_issue[retire_idx] + 3, cyc);
                check_value("retire_op", int'(exp_op[retire_idx]), int'(retire_op));
                check_value("retire_dst", int'(exp_dst[retire_idx]), int'(retire_dst));
            end
            else
            begin
                errors++;
                $display("retire at time %0t with no instruction expected", $time);
            end
            retire_idx++;
        end
    end

    // Ends a run that stops making progress
    initial
    begin
        #(8 * EST_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", 8 * EST_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int         i;
        int         sel;
        int         gap;
        logic [6:0] op;
        in_valid <= 1'b0;
        op_code  <= '0;
        src1     <= '0;
        src2     <= '0;
        dst      <= '0;
        @(posedge clk);
        while (!rst_n)
            @(posedge clk);
        check_value("issue_valid after reset", 0, int'(issue_valid));
        check_value("retire_valid after reset", 0, int'(retire_valid));
        check_value("overflow after reset", 0, int'(overflow));

        // Independent stream at one per cycle
        begin_test();
        send_instr(OP_R_TYPE, 5'd10, 5'd11, 5'd1, 0);
        send_instr(OP_I_ALU, 5'd12, 5'd0, 5'd2, 0);
        send_instr(OP_LOAD, 5'd13, 5'd14, 5'd3, 0);
        send_instr(OP_STORE, 5'd14, 5'd15, 5'd0, 0);
        send_instr(OP_BRANCH, 5'd16, 5'd17, 5'd0, 0);
        send_instr(OP_JALR, 5'd18, 5'd19, 5'd4, 0);
        end_test("independent");

        // Back-to-back dependency and then one two instructions back
        begin_test();
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd5, 0);
        send_instr(OP_R_TYPE, 5'd5, 5'd3, 5'd6, 3);
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd7, 0);
        send_instr(OP_I_ALU, 5'd9, 5'd0, 5'd8, 0);
        send_instr(OP_R_TYPE, 5'd4, 5'd7, 5'd10, 0);
        end_test("dependency");

        // src2 of load and JALR is an immediate field
        begin_test();
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd5, 0);
        send_instr(OP_LOAD, 5'd3, 5'd5, 5'd6, 0);
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd7, 0);
        send_instr(OP_JALR, 5'd3, 5'd7, 5'd8, 3);
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd9, 0);
        send_instr(OP_STORE, 5'd4, 5'd9, 5'd0, 0);
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd11, 0);
        send_instr(OP_BRANCH, 5'd11, 5'd4, 5'd0, 3);
        // Store and branch write nothing despite a dst field
        send_instr(OP_STORE, 5'd1, 5'd2, 5'd12, 0);
        send_instr(OP_R_TYPE, 5'd12, 5'd12, 5'd13, 0);
        send_instr(OP_BRANCH, 5'd1, 5'd2, 5'd14, 0);
        send_instr(OP_I_ALU, 5'd14, 5'd0, 5'd15, 0);
        end_test("source usage");

        // x0 as nop, as a source and as a destination
        begin_test();
        send_instr(OP_R_TYPE, 5'd0, 5'd0, 5'd0, 0);
        send_instr(OP_R_TYPE, 5'd0, 5'd0, 5'd3, 0);
        send_instr(OP_I_ALU, 5'd1, 5'd0, 5'd0, 0);
        send_instr(OP_R_TYPE, 5'd0, 5'd0, 5'd4, 0);
        send_instr(OP_R_TYPE, 5'd1, 5'd2, 5'd9, 0);
        send_instr(OP_UNKNOWN, 5'd9, 5'd9, 5'd9, 0);
        end_test("register zero");

        // Dependent chain where each stalls two cycles and the queue fills
        begin_test();
        for (i = 0; i < 10; i++)
            send_instr(OP_R_TYPE, reg_idx_t'(i + 1), 5'd0, reg_idx_t'(i + 2), 0);
        // First drops happen well before the last strobe
        check_value("overflow during chain", 1, int'(overflow));
        end_test("overflow");

        // Few registers so that hazards are frequent
        begin_test();
        for (i = 0; i < RANDOM_COUNT; i++)
        begin
            sel = {$random(seed)} % 7;
            gap = {$random(seed)} % 3;
            case (sel)
                0: op = OP_R_TYPE;
                1: op = OP_I_ALU;
                2: op = OP_LOAD;
                3: op = OP_STORE;
                4: op = OP_BRANCH;
                5: op = OP_JALR;
                default: op = OP_UNKNOWN;
            endcase
            send_instr(op, reg_idx_t'({$random(seed)} % 8), reg_idx_t'({$random(seed)} % 8),
                       reg_idx_t'({$random(seed)} % 8), gap);
        end
        end_test("random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/pipe_pkg.sv
design/instr_decoder.sv
design/instr_queue.sv
design/hazard_detector.sv
design/issue_pipeline.sv
design/issue_top.sv
tests/clock_gen.sv
tests/issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compiles with Verilator and runs the testbench; exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module issue_tb \
    -Mdir obj_dir -o issue_sim &&
./obj_dir/issue_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
